// File: bus_ctrl_consts.svh
`ifndef BUS_CTRL_CONSTS_SVH
`define BUS_CTRL_CONSTS_SVH

////////////////////
// Bus widths
`define ADDR_W 16
`define DATA_W 16
`define UART_W 8

////////////////////
// Address map

// Power of two, upper address bits pick the bank
`define NUM_BANKS 2
`define BANK_ADDR_W (`ADDR_W - $clog2(`NUM_BANKS))

// Decoded ahead of the bank select
`define UART_DATA_ADDR 16'hBF00
`define UART_STAT_ADDR 16'hBF01

////////////////////
// Timing and depths
`define SRAM_WAIT 2
`define UART_PULSE 2
`define RX_DEPTH 8

`endif

// File: bus_ctrl_pkg.sv
`default_nettype none

package bus_ctrl_pkg;

	typedef enum logic {
		OP_READ,
		OP_WRITE
	} mem_op_e;

	typedef enum logic {
		DEC_IDLE,
		DEC_BUSY
	} dec_state_e;

	typedef enum logic [2:0] {
		SR_IDLE,
		SR_SETUP,
		SR_STROBE,
		SR_HOLD,
		SR_ACK
	} sram_state_e;

	typedef enum logic [2:0] {
		UA_IDLE,
		UA_RX_PULSE,
		UA_RX_STORE,
		UA_TX_PULSE,
		UA_TX_WAIT_TBRE,
		UA_TX_WAIT_TSRE,
		UA_REG_READ,
		UA_ACK
	} uart_state_e;

endpackage

`default_nettype wire

// File: mem_req_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "bus_ctrl_consts.svh"

// Four-phase request channel to one target
interface mem_req_if;

	logic req;
	logic ack;
	bus_ctrl_pkg::mem_op_e op;
	logic [`BANK_ADDR_W-1:0] addr;
	logic [`DATA_W-1:0] wdata;
	logic [`DATA_W-1:0] rdata;

	modport initiator (
		output req, op, addr, wdata
	);

	modport target (
		input req, op, addr, wdata,
		output ack, rdata
	);

	modport monitor (
		input ack, rdata
	);

endinterface

`default_nettype wire

// File: uart_rx_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "bus_ctrl_consts.svh"

module uart_rx_fifo (
	input  logic                clk,
	input  logic                rst,
	input  logic                push,
	input  logic [`UART_W-1:0]  push_data,
	input  logic                pop,
	output logic [`UART_W-1:0]  pop_data,
	output logic                empty,
	output logic                full
);

	localparam int PTR_W = $clog2(`RX_DEPTH);
	localparam logic [PTR_W:0] DEPTH = (PTR_W + 1)'(`RX_DEPTH);

	logic [`UART_W-1:0] mem [`RX_DEPTH];
	logic [PTR_W-1:0] front;
	logic [PTR_W-1:0] tail;
	logic [PTR_W:0] count;
	logic do_push;
	logic do_pop;

	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	// Pointers wrap on their own since the depth is a power of two
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			front <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			if (do_push)
				tail <= tail + 1'b1;
			if (do_pop)
				front <= front + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_push)
			mem[tail] <= push_data;
	end

	assign pop_data = mem[front];
	assign empty = (count == '0);
	assign full = (count == DEPTH);

endmodule

`default_nettype wire

// File: bus_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "bus_ctrl_consts.svh"

module bus_decoder (
	input  logic                clk,
	input  logic                rst,
	input  logic                host_req,
	input  logic                host_wr,
	input  logic [`ADDR_W-1:0]  host_addr,
	input  logic [`DATA_W-1:0]  host_wdata,
	mem_req_if.initiator        bank [`NUM_BANKS],
	mem_req_if.initiator        uart
);

	localparam int SEL_W = `ADDR_W - `BANK_ADDR_W;

	bus_ctrl_pkg::dec_state_e state;
	logic tgt_req;
	logic sel_uart;
	logic [SEL_W-1:0] sel_bank;
	logic start;
	logic hit_uart;

	bus_ctrl_pkg::mem_op_e lat_op;
	logic [`BANK_ADDR_W-1:0] lat_addr;
	logic [`DATA_W-1:0] lat_wdata;

	assign start = (state == bus_ctrl_pkg::DEC_IDLE) && host_req;

	// UART addresses sit inside a bank range, so they win
	assign hit_uart = (host_addr == `UART_DATA_ADDR) || (host_addr == `UART_STAT_ADDR);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= bus_ctrl_pkg::DEC_IDLE;
			tgt_req <= 1'b0;
			sel_uart <= 1'b0;
			sel_bank <= '0;
		end else begin
			case (state)
				bus_ctrl_pkg::DEC_IDLE: begin
					if (host_req) begin
						sel_uart <= hit_uart;
						sel_bank <= host_addr[`ADDR_W-1 -: SEL_W];
						tgt_req <= 1'b1;
						state <= bus_ctrl_pkg::DEC_BUSY;
					end
				end
				bus_ctrl_pkg::DEC_BUSY: begin
					if (!host_req) begin
						tgt_req <= 1'b0;
						state <= bus_ctrl_pkg::DEC_IDLE;
					end
				end
				default: state <= bus_ctrl_pkg::DEC_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			lat_op <= host_wr ? bus_ctrl_pkg::OP_WRITE : bus_ctrl_pkg::OP_READ;
			lat_addr <= host_addr[`BANK_ADDR_W-1:0];
			lat_wdata <= host_wdata;
		end
	end

	for (genvar i = 0; i < `NUM_BANKS; i++) begin : g_bank
		assign bank[i].req = tgt_req && !sel_uart && (sel_bank == SEL_W'(i));
		assign bank[i].op = lat_op;
		assign bank[i].addr = lat_addr;
		assign bank[i].wdata = lat_wdata;
	end

	assign uart.req = tgt_req && sel_uart;
	assign uart.op = lat_op;
	assign uart.addr = lat_addr;
	assign uart.wdata = lat_wdata;

endmodule

`default_nettype wire

// File: sram_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "bus_ctrl_consts.svh"

module sram_port (
	input  logic                     clk,
	input  logic                     rst,
	mem_req_if.target                bus,
	output logic [`BANK_ADDR_W-1:0]  sram_addr,
	output logic [`DATA_W-1:0]       sram_dout,
	input  logic [`DATA_W-1:0]       sram_din,
	output logic                     sram_dout_en,
	output logic                     sram_en,
	output logic                     sram_oe,
	output logic                     sram_we
);

	localparam int CNT_W = $clog2(`SRAM_WAIT + 1);
	localparam logic [CNT_W-1:0] LAST = CNT_W'(`SRAM_WAIT - 1);

	bus_ctrl_pkg::sram_state_e state;
	logic [CNT_W-1:0] cnt;
	logic [`DATA_W-1:0] rd_word;
	logic active;
	logic is_write;
	logic strobe_end;

	assign is_write = (bus.op == bus_ctrl_pkg::OP_WRITE);
	assign strobe_end = (state == bus_ctrl_pkg::SR_STROBE) && (cnt == LAST);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= bus_ctrl_pkg::SR_IDLE;
			cnt <= '0;
		end else begin
			case (state)
				bus_ctrl_pkg::SR_IDLE: begin
					if (bus.req)
						state <= bus_ctrl_pkg::SR_SETUP;
				end
				bus_ctrl_pkg::SR_SETUP: begin
					cnt <= '0;
					state <= bus_ctrl_pkg::SR_STROBE;
				end
				bus_ctrl_pkg::SR_STROBE: begin
					if (strobe_end)
						state <= bus_ctrl_pkg::SR_HOLD;
					else
						cnt <= cnt + 1'b1;
				end
				bus_ctrl_pkg::SR_HOLD: state <= bus_ctrl_pkg::SR_ACK;
				// Held until the decoder drops req
				bus_ctrl_pkg::SR_ACK: begin
					if (!bus.req)
						state <= bus_ctrl_pkg::SR_IDLE;
				end
				default: state <= bus_ctrl_pkg::SR_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (strobe_end && !is_write)
			rd_word <= sram_din;
	end

	assign active = (state == bus_ctrl_pkg::SR_SETUP) ||
		(state == bus_ctrl_pkg::SR_STROBE) ||
		(state == bus_ctrl_pkg::SR_HOLD);

	// Chip strobes, all active low
	assign sram_en = !active;
	assign sram_oe = !((state == bus_ctrl_pkg::SR_STROBE) && !is_write);
	assign sram_we = !((state == bus_ctrl_pkg::SR_STROBE) && is_write);
	assign sram_dout_en = active && is_write;

	assign sram_addr = bus.addr;
	assign sram_dout = bus.wdata;

	assign bus.ack = (state == bus_ctrl_pkg::SR_ACK);
	assign bus.rdata = rd_word;

endmodule

`default_nettype wire

// File: uart_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "bus_ctrl_consts.svh"

module uart_port (
	input  logic                clk,
	input  logic                rst,
	mem_req_if.target           bus,
	input  logic                data_ready,
	input  logic                tbre,
	input  logic                tsre,
	input  logic [`UART_W-1:0]  uart_rx_data,
	output logic                rdn,
	output logic                wrn,
	output logic [`UART_W-1:0]  uart_tx_data
);

	localparam int CNT_W = $clog2(`UART_PULSE + 1);
	localparam logic [CNT_W-1:0] LAST = CNT_W'(`UART_PULSE - 1);
	localparam logic [`ADDR_W-1:0] STAT_ADDR = `UART_STAT_ADDR;

	bus_ctrl_pkg::uart_state_e state;
	logic [CNT_W-1:0] cnt;
	logic tx_idle;
	logic [`DATA_W-1:0] rd_word;
	logic is_stat;
	logic is_write;

	logic rx_push;
	logic rx_pop;
	logic [`UART_W-1:0] rx_data;
	logic rx_empty;
	logic rx_full;

	assign is_stat = (bus.addr == STAT_ADDR[`BANK_ADDR_W-1:0]);
	assign is_write = (bus.op == bus_ctrl_pkg::OP_WRITE);

	////////////////////
	// Sequencer
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= bus_ctrl_pkg::UA_IDLE;
			cnt <= '0;
			tx_idle <= 1'b1;
		end else begin
			case (state)
				bus_ctrl_pkg::UA_IDLE: begin
					cnt <= '0;
					// Receive first, a full queue leaves the byte in the chip
					if (data_ready && !rx_full)
						state <= bus_ctrl_pkg::UA_RX_PULSE;
					else if (bus.req) begin
						if (!is_write)
							state <= bus_ctrl_pkg::UA_REG_READ;
						else if (is_stat)
							state <= bus_ctrl_pkg::UA_ACK;
						else begin
							tx_idle <= 1'b0;
							state <= bus_ctrl_pkg::UA_TX_PULSE;
						end
					end
				end
				bus_ctrl_pkg::UA_RX_PULSE: begin
					if (cnt == LAST)
						state <= bus_ctrl_pkg::UA_RX_STORE;
					else
						cnt <= cnt + 1'b1;
				end
				bus_ctrl_pkg::UA_RX_STORE: state <= bus_ctrl_pkg::UA_IDLE;
				bus_ctrl_pkg::UA_TX_PULSE: begin
					if (cnt == LAST)
						state <= bus_ctrl_pkg::UA_TX_WAIT_TBRE;
					else
						cnt <= cnt + 1'b1;
				end
				bus_ctrl_pkg::UA_TX_WAIT_TBRE: begin
					if (tbre)
						state <= bus_ctrl_pkg::UA_TX_WAIT_TSRE;
				end
				bus_ctrl_pkg::UA_TX_WAIT_TSRE: begin
					if (tsre) begin
						tx_idle <= 1'b1;
						state <= bus_ctrl_pkg::UA_ACK;
					end
				end
				bus_ctrl_pkg::UA_REG_READ: state <= bus_ctrl_pkg::UA_ACK;
				bus_ctrl_pkg::UA_ACK: begin
					if (!bus.req)
						state <= bus_ctrl_pkg::UA_IDLE;
				end
				default: state <= bus_ctrl_pkg::UA_IDLE;
			endcase
		end
	end

	// Read word, empty queue reads as zero
	always_ff @(posedge clk) begin
		if (state == bus_ctrl_pkg::UA_REG_READ) begin
			if (is_stat)
				rd_word <= {{(`DATA_W - 2){1'b0}}, tx_idle, !rx_empty};
			else if (rx_empty)
				rd_word <= '0;
			else
				rd_word <= {{(`DATA_W - `UART_W){1'b0}}, rx_data};
		end
	end

	assign rx_push = (state == bus_ctrl_pkg::UA_RX_STORE);
	assign rx_pop = (state == bus_ctrl_pkg::UA_REG_READ) && !is_stat;

	uart_rx_fifo u_rx_fifo (
		.clk       (clk),
		.rst       (rst),
		.push      (rx_push),
		.push_data (uart_rx_data),
		.pop       (rx_pop),
		.pop_data  (rx_data),
		.empty     (rx_empty),
		.full      (rx_full)
	);

	assign rdn = (state != bus_ctrl_pkg::UA_RX_PULSE);
	assign wrn = (state != bus_ctrl_pkg::UA_TX_PULSE);
	assign uart_tx_data = bus.wdata[`UART_W-1:0];

	assign bus.ack = (state == bus_ctrl_pkg::UA_ACK);
	assign bus.rdata = rd_word;

endmodule

`default_nettype wire

// File: resp_collector.sv
`timescale 1ns/1ps
`default_nettype none

`include "bus_ctrl_consts.svh"

module resp_collector (
	input  logic                clk,
	input  logic                rst,
	mem_req_if.monitor          bank [`NUM_BANKS],
	mem_req_if.monitor          uart,
	output logic                host_ack,
	output logic [`DATA_W-1:0]  host_rdata
);

	logic [`NUM_BANKS-1:0] bank_ack;
	logic [`DATA_W-1:0] bank_rdata [`NUM_BANKS];
	logic any_ack;
	logic [`DATA_W-1:0] sel_rdata;

	for (genvar i = 0; i < `NUM_BANKS; i++) begin : g_bank
		assign bank_ack[i] = bank[i].ack;
		assign bank_rdata[i] = bank[i].rdata;
	end

	assign any_ack = uart.ack || (|bank_ack);

	// Only one target acks at a time
	always_comb begin
		sel_rdata = uart.rdata;
		for (int i = 0; i < `NUM_BANKS; i++) begin
			if (bank_ack[i])
				sel_rdata = bank_rdata[i];
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst)
			host_ack <= 1'b0;
		else
			host_ack <= any_ack;
	end

	always_ff @(posedge clk) begin
		if (any_ack)
			host_rdata <= sel_rdata;
	end

endmodule

`default_nettype wire

// File: bus_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "bus_ctrl_consts.svh"

module bus_ctrl_top (
	input  logic                                    clk,
	input  logic                                    rst,
	input  logic                                    req,
	input  logic                                    wr,
	input  logic [`ADDR_W-1:0]                      addr,
	input  logic [`DATA_W-1:0]                      wdata,
	output logic                                    ack,
	output logic [`DATA_W-1:0]                      rdata,

	output logic [`NUM_BANKS-1:0][`BANK_ADDR_W-1:0] sram_addr,
	output logic [`NUM_BANKS-1:0][`DATA_W-1:0]      sram_dout,
	input  logic [`NUM_BANKS-1:0][`DATA_W-1:0]      sram_din,
	output logic [`NUM_BANKS-1:0]                   sram_dout_en,
	output logic [`NUM_BANKS-1:0]                   sram_en,
	output logic [`NUM_BANKS-1:0]                   sram_oe,
	output logic [`NUM_BANKS-1:0]                   sram_we,

	input  logic                                    data_ready,
	input  logic                                    tbre,
	input  logic                                    tsre,
	input  logic [`UART_W-1:0]                      uart_rx_data,
	output logic                                    rdn,
	output logic                                    wrn,
	output logic [`UART_W-1:0]                      uart_tx_data
);

	mem_req_if bank_if [`NUM_BANKS] ();
	mem_req_if uart_if ();

	bus_decoder u_decoder (
		.clk        (clk),
		.rst        (rst),
		.host_req   (req),
		.host_wr    (wr),
		.host_addr  (addr),
		.host_wdata (wdata),
		.bank       (bank_if),
		.uart       (uart_if)
	);

	////////////////////
	// SRAM banks
	for (genvar i = 0; i < `NUM_BANKS; i++) begin : g_sram
		sram_port u_sram (
			.clk          (clk),
			.rst          (rst),
			.bus          (bank_if[i]),
			.sram_addr    (sram_addr[i]),
			.sram_dout    (sram_dout[i]),
			.sram_din     (sram_din[i]),
			.sram_dout_en (sram_dout_en[i]),
			.sram_en      (sram_en[i]),
			.sram_oe      (sram_oe[i]),
			.sram_we      (sram_we[i])
		);
	end

	uart_port u_uart (
		.clk          (clk),
		.rst          (rst),
		.bus          (uart_if),
		.data_ready   (data_ready),
		.tbre         (tbre),
		.tsre         (tsre),
		.uart_rx_data (uart_rx_data),
		.rdn          (rdn),
		.wrn          (wrn),
		.uart_tx_data (uart_tx_data)
	);

	resp_collector u_collector (
		.clk        (clk),
		.rst        (rst),
		.bank       (bank_if),
		.uart       (uart_if),
		.host_ack   (ack),
		.host_rdata (rdata)
	);

endmodule

`default_nettype wire

// File: tb_devices.sv
`timescale 1ns/1ps
`default_nettype none

`include "bus_ctrl_consts.svh"

// SRAM banks and UART chip seen from the board pins
module tb_devices (
	input  logic                                    clk,
	input  logic                                    rst,
	input  logic [`NUM_BANKS-1:0][`BANK_ADDR_W-1:0] sram_addr,
	input  logic [`NUM_BANKS-1:0][`DATA_W-1:0]      sram_dout,
	output logic [`NUM_BANKS-1:0][`DATA_W-1:0]      sram_din,
	input  logic [`NUM_BANKS-1:0]                   sram_dout_en,
	input  logic [`NUM_BANKS-1:0]                   sram_en,
	input  logic [`NUM_BANKS-1:0]                   sram_oe,
	input  logic [`NUM_BANKS-1:0]                   sram_we,
	output logic                                    data_ready,
	output logic                                    tbre,
	output logic                                    tsre,
	output logic [`UART_W-1:0]                      uart_rx_data,
	input  logic                                    rdn,
	input  logic                                    wrn,
	input  logic [`UART_W-1:0]                      uart_tx_data,
	input  logic                                    rx_inject,
	input  logic [`UART_W-1:0]                      rx_inject_data,
	input  logic [3:0]                              tbre_delay,
	input  logic [3:0]                              tsre_delay,
	output logic [7:0]                              tx_count,
	output logic [`UART_W-1:0]                      tx_byte
);

	localparam int WORDS = 1 << `BANK_ADDR_W;

	logic [`DATA_W-1:0] mem [`NUM_BANKS][WORDS];
	logic [`UART_W-1:0] rx_buf [64];
	logic [5:0] rx_wr;
	logic [5:0] rx_rd;
	logic [`UART_W-1:0] rx_out;
	logic rdn_q;
	logic wrn_q;
	logic [3:0] delay;

	function automatic logic [`DATA_W-1:0] fill_word(input logic [`ADDR_W-1:0] a);
		return {a[7:0], a[15:8]} ^ 16'h3c5a;
	endfunction

	initial begin
		for (int b = 0; b < `NUM_BANKS; b++)
			for (int a = 0; a < WORDS; a++)
				mem[b][a] <= fill_word(`ADDR_W'(b * WORDS + a));
	end

	////////////////////
	// SRAM banks
	for (genvar i = 0; i < `NUM_BANKS; i++) begin : g_bank
		assign sram_din[i] = (!sram_en[i] && !sram_oe[i]) ? mem[i][sram_addr[i]] : '0;
	end

	always @(posedge clk) begin
		for (int i = 0; i < `NUM_BANKS; i++)
			if (!sram_en[i] && !sram_we[i] && sram_dout_en[i])
				mem[i][sram_addr[i]] <= sram_dout[i];
	end

	////////////////////
	// UART chip
	assign data_ready = (rx_wr != rx_rd);
	assign uart_rx_data = rx_out;

	always @(posedge clk) begin
		if (rx_inject)
			rx_buf[rx_wr] <= rx_inject_data;
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			rx_wr <= '0;
			rx_rd <= '0;
			rx_out <= '0;
			rdn_q <= 1'b1;
		end else begin
			rdn_q <= rdn;
			if (rx_inject)
				rx_wr <= rx_wr + 1'b1;
			// Front byte moves to the data pins once rdn goes low
			if (!rdn && rdn_q) begin
				rx_out <= rx_buf[rx_rd];
				rx_rd <= rx_rd + 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wrn_q <= 1'b1;
			tbre <= 1'b1;
			tsre <= 1'b1;
			delay <= '0;
			tx_count <= '0;
			tx_byte <= '0;
		end else begin
			wrn_q <= wrn;
			if (!wrn && wrn_q) begin
				tx_byte <= uart_tx_data;
				tx_count <= tx_count + 1'b1;
				tbre <= 1'b0;
				tsre <= 1'b0;
				delay <= tbre_delay;
			end else if (!tbre) begin
				if (delay == '0) begin
					tbre <= 1'b1;
					delay <= tsre_delay;
				end else
					delay <= delay - 1'b1;
			end else if (!tsre) begin
				if (delay == '0)
					tsre <= 1'b1;
				else
					delay <= delay - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: tb_bus_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "bus_ctrl_consts.svh"

module tb_bus_ctrl;

	localparam int N_SRAM = 200;
	localparam int N_TX = 12;
	localparam int N_RX = 6;
	localparam int N_BP = `RX_DEPTH + 3;
	localparam int N_TRANS = N_SRAM + 8 + 2 * N_TX + 2 * N_RX + 2 + 2 * N_BP + 2;
	localparam int CYCLE_LIMIT = N_TRANS * 64 + 1000;
	localparam logic [`ADDR_W-1:0] DATA_ADDR = `UART_DATA_ADDR;
	localparam logic [`ADDR_W-1:0] STAT_ADDR = `UART_STAT_ADDR;
	localparam logic [`ADDR_W-1:0] BANK_BIT = `ADDR_W'(1 << `BANK_ADDR_W);
	localparam int UART_BANK = `UART_DATA_ADDR >> `BANK_ADDR_W;
	localparam int UART_LOCAL = `UART_DATA_ADDR % (1 << `BANK_ADDR_W);

	logic clk = 1'b0;
	logic rst;
	logic req;
	logic wr;
	logic [`ADDR_W-1:0] addr;
	logic [`DATA_W-1:0] wdata;
	logic ack;
	logic [`DATA_W-1:0] rdata;

	logic [`NUM_BANKS-1:0][`BANK_ADDR_W-1:0] sram_addr;
	logic [`NUM_BANKS-1:0][`DATA_W-1:0] sram_dout;
	logic [`NUM_BANKS-1:0][`DATA_W-1:0] sram_din;
	logic [`NUM_BANKS-1:0] sram_dout_en;
	logic [`NUM_BANKS-1:0] sram_en;
	logic [`NUM_BANKS-1:0] sram_oe;
	logic [`NUM_BANKS-1:0] sram_we;

	logic data_ready;
	logic tbre;
	logic tsre;
	logic [`UART_W-1:0] uart_rx_data;
	logic rdn;
	logic wrn;
	logic [`UART_W-1:0] uart_tx_data;
	logic rx_inject;
	logic [`UART_W-1:0] rx_inject_data;
	logic [3:0] tbre_delay;
	logic [3:0] tsre_delay;
	logic [7:0] tx_count;
	logic [`UART_W-1:0] tx_byte;

	logic [31:0] seed = 32'hdb81_dcc2;
	logic [`DATA_W-1:0] model_mem [1 << `ADDR_W];
	logic [`UART_W-1:0] rx_expect [$];
	int check_errors = 0;
	int ack_errors = 0;
	int cycles = 0;
	logic ack_prev = 1'b0;
	logic req_seen = 1'b0;

	always #20 clk = ~clk;

	bus_ctrl_top uut (
		.clk          (clk),
		.rst          (rst),
		.req          (req),
		.wr           (wr),
		.addr         (addr),
		.wdata        (wdata),
		.ack          (ack),
		.rdata        (rdata),
		.sram_addr    (sram_addr),
		.sram_dout    (sram_dout),
		.sram_din     (sram_din),
		.sram_dout_en (sram_dout_en),
		.sram_en      (sram_en),
		.sram_oe      (sram_oe),
		.sram_we      (sram_we),
		.data_ready   (data_ready),
		.tbre         (tbre),
		.tsre         (tsre),
		.uart_rx_data (uart_rx_data),
		.rdn          (rdn),
		.wrn          (wrn),
		.uart_tx_data (uart_tx_data)
	);

	tb_devices devs (
		.clk            (clk),
		.rst            (rst),
		.sram_addr      (sram_addr),
		.sram_dout      (sram_dout),
		.sram_din       (sram_din),
		.sram_dout_en   (sram_dout_en),
		.sram_en        (sram_en),
		.sram_oe        (sram_oe),
		.sram_we        (sram_we),
		.data_ready     (data_ready),
		.tbre           (tbre),
		.tsre           (tsre),
		.uart_rx_data   (uart_rx_data),
		.rdn            (rdn),
		.wrn            (wrn),
		.uart_tx_data   (uart_tx_data),
		.rx_inject      (rx_inject),
		.rx_inject_data (rx_inject_data),
		.tbre_delay     (tbre_delay),
		.tsre_delay     (tsre_delay),
		.tx_count       (tx_count),
		.tx_byte        (tx_byte)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] rand_word();
		seed = xorshift(seed);
		return seed;
	endfunction

	// Power-up contents of the SRAM chips
	function automatic logic [`DATA_W-1:0] fill_word(input logic [`ADDR_W-1:0] a);
		return {a[7:0], a[15:8]} ^ 16'h3c5a;
	endfunction

	task automatic report_mismatch(input string name, input logic [`DATA_W-1:0] exp,
			input logic [`DATA_W-1:0] act);
		check_errors++;
		$display("FAILED %s: expected %h, actual %h", name, exp, act);
	endtask

	// One four-phase access driven on the falling edge
	task automatic host_access(input logic is_wr, input logic [`ADDR_W-1:0] a,
			input logic [`DATA_W-1:0] d, output logic [`DATA_W-1:0] rd);
		@(negedge clk);
		if (ack !== 1'b0) begin
			check_errors++;
			$display("Handshake error: ack still high as the access to %h starts", a);
		end
		req = 1'b1;
		wr = is_wr;
		addr = a;
		wdata = d;
		@(negedge clk);
		while (!ack)
			@(negedge clk);
		rd = rdata;
		req = 1'b0;
		@(negedge clk);
		while (ack)
			@(negedge clk);
	endtask

	task automatic inject_byte(input logic [`UART_W-1:0] b);
		@(negedge clk);
		rx_inject = 1'b1;
		rx_inject_data = b;
		rx_expect.push_back(b);
		@(negedge clk);
		rx_inject = 1'b0;
	endtask

	task automatic check_shadow(input string name);
		if (devs.mem[UART_BANK][UART_LOCAL] !== fill_word(DATA_ADDR))
			report_mismatch(name, fill_word(DATA_ADDR), devs.mem[UART_BANK][UART_LOCAL]);
		if (devs.mem[UART_BANK][UART_LOCAL + 1] !== fill_word(STAT_ADDR))
			report_mismatch(name, fill_word(STAT_ADDR), devs.mem[UART_BANK][UART_LOCAL + 1]);
	endtask

	////////////////////
	// Tests
	task automatic test_sram();
		logic [31:0] r;
		logic [`ADDR_W-1:0] a;
		logic [`DATA_W-1:0] got;
		for (int i = 0; i < N_SRAM; i++) begin
			r = rand_word();
			// Small window in each bank so reads hit written words
			a = {r[31], 10'h000, r[20:16]};
			if (r[24]) begin
				host_access(1'b1, a, r[15:0], got);
				model_mem[a] = r[15:0];
			end else begin
				host_access(1'b0, a, '0, got);
				if (got !== model_mem[a])
					report_mismatch("sram random", model_mem[a], got);
			end
		end
	endtask

	task automatic test_map();
		logic [31:0] r;
		logic [`ADDR_W-1:0] lo;
		logic [`ADDR_W-1:0] alias_addr;
		logic [`DATA_W-1:0] got;
		logic [7:0] count_before;
		r = rand_word();
		lo = 16'h0123;
		host_access(1'b1, lo, r[15:0], got);
		model_mem[lo] = r[15:0];
		host_access(1'b1, lo | BANK_BIT, ~r[15:0], got);
		model_mem[lo | BANK_BIT] = ~r[15:0];
		host_access(1'b0, lo, '0, got);
		if (got !== model_mem[lo])
			report_mismatch("map bank 0", model_mem[lo], got);
		host_access(1'b0, lo | BANK_BIT, '0, got);
		if (got !== model_mem[lo | BANK_BIT])
			report_mismatch("map bank 1", model_mem[lo | BANK_BIT], got);

		// Status write is acked and changes nothing
		count_before = tx_count;
		host_access(1'b1, STAT_ADDR, 16'hffff, got);
		if (tx_count !== count_before) begin
			check_errors++;
			$display("Status write started a UART transmit");
		end
		host_access(1'b0, STAT_ADDR, '0, got);
		if (got !== 16'h0002)
			report_mismatch("map status", 16'h0002, got);
		alias_addr = DATA_ADDR & ~BANK_BIT;
		host_access(1'b0, alias_addr, '0, got);
		if (got !== model_mem[alias_addr])
			report_mismatch("map alias", model_mem[alias_addr], got);
		host_access(1'b0, alias_addr + 1'b1, '0, got);
		if (got !== model_mem[alias_addr + 1'b1])
			report_mismatch("map alias", model_mem[alias_addr + 1'b1], got);
		check_shadow("map shadow word");
	endtask

	task automatic test_tx();
		logic [31:0] r;
		logic [7:0] count_before;
		logic [`DATA_W-1:0] got;
		for (int i = 0; i < N_TX; i++) begin
			r = rand_word();
			tbre_delay = r[3:0];
			tsre_delay = r[7:4];
			count_before = tx_count;
			host_access(1'b1, DATA_ADDR, {r[31:24], r[15:8]}, got);
			if (tx_count !== count_before + 8'd1) begin
				check_errors++;
				$display("Transmit write %0d did not reach the chip exactly once", i);
			end
			if (tx_byte !== r[15:8])
				report_mismatch("uart transmit", {8'h00, r[15:8]}, {8'h00, tx_byte});
			host_access(1'b0, STAT_ADDR, '0, got);
			if (got !== 16'h0002)
				report_mismatch("tx status", 16'h0002, got);
		end
		check_shadow("tx shadow word");
	endtask

	task automatic drain_rx(input string name);
		logic [`DATA_W-1:0] got;
		logic [`DATA_W-1:0] exp;
		while (rx_expect.size() != 0) begin
			host_access(1'b0, STAT_ADDR, '0, got);
			if (got !== 16'h0003)
				report_mismatch({name, " status"}, 16'h0003, got);
			exp = {8'h00, rx_expect.pop_front()};
			host_access(1'b0, DATA_ADDR, '0, got);
			if (got !== exp)
				report_mismatch({name, " data"}, exp, got);
		end
		host_access(1'b0, STAT_ADDR, '0, got);
		if (got !== 16'h0002)
			report_mismatch({name, " empty status"}, 16'h0002, got);
		host_access(1'b0, DATA_ADDR, '0, got);
		if (got !== 16'h0000)
			report_mismatch({name, " empty read"}, 16'h0000, got);
	endtask

	task automatic test_rx(input string name, input int n);
		logic [31:0] r;
		for (int i = 0; i < n; i++) begin
			r = rand_word();
			inject_byte(r[7:0]);
		end
		drain_rx(name);
		if (data_ready !== 1'b0) begin
			check_errors++;
			$display("UART chip still holds bytes after the %s test", name);
		end
	endtask

	////////////////////
	// Monitors
	always @(posedge clk) begin
		if (rst) begin
			if (req)
				req_seen = 1'b1;
			if (ack && !ack_prev && !req_seen) begin
				ack_errors++;
				$display("Handshake error: ack rose without a request");
			end
			if (!ack && ack_prev) begin
				if (req) begin
					ack_errors++;
					$display("Handshake error: ack fell while req was still high");
				end
				req_seen = 1'b0;
			end
		end
		ack_prev = ack;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Errors: %0d check, %0d handshake", check_errors, ack_errors);
			$display("Verification failed");
			$finish;
		end
	end

	initial begin
		rst = 1'b0;
		req = 1'b0;
		wr = 1'b0;
		addr = '0;
		wdata = '0;
		rx_inject = 1'b0;
		rx_inject_data = '0;
		tbre_delay = '0;
		tsre_delay = '0;
		for (int i = 0; i < (1 << `ADDR_W); i++)
			model_mem[i] = fill_word(`ADDR_W'(i));

		repeat (3) @(negedge clk);
		rst = 1'b1;
		@(negedge clk);
		if (ack !== 1'b0) begin
			check_errors++;
			$display("Handshake error: ack is not low after reset");
		end

		test_sram();
		test_map();
		test_tx();
		test_rx("uart receive", N_RX);
		test_rx("back-pressure", N_BP);

		$display("Errors: %0d check, %0d handshake", check_errors, ack_errors);
		if (check_errors == 0 && ack_errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
+incdir+.
bus_ctrl_pkg.sv
mem_req_if.sv
uart_rx_fifo.sv
bus_decoder.sv
sram_port.sv
uart_port.sv
resp_collector.sv
bus_ctrl_top.sv
tb_devices.sv
tb_bus_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# Build the bus controller testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module tb_bus_ctrl -o tb_bus_ctrl
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_bus_ctrl)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "Verification passed"; then
	exit 0
fi
exit 1
